// File: rtl/mmio_test_pkg.sv
package mmio_test_pkg;

    // One 64-bit MMIO register word
    typedef logic [63:0] t_mmio_value;

    // The 512-bit port records eight register words, lane 0 in the low bits
    typedef t_mmio_value [7:0] t_mmio_line;

    // Register index, counted in 64-bit words of the MMIO space
    typedef logic [11:0] t_csr_idx;

    // ====================
    // Register map
    // ====================

    // Header group, reduced together in the first read stage
    localparam t_csr_idx CSR_DFH        = 12'h000;
    localparam t_csr_idx CSR_ID_L       = 12'h001;
    localparam t_csr_idx CSR_ID_H       = 12'h002;
    localparam t_csr_idx CSR_REQ_ADDR   = 12'h008;

    localparam t_csr_idx CSR_STATUS     = 12'h010;

    // Recorded state of the 64-bit port
    localparam t_csr_idx CSR_WR64_DATA  = 12'h020;
    localparam t_csr_idx CSR_WR64_ADDR  = 12'h030;
    localparam t_csr_idx CSR_WR64_MASK  = 12'h031;

    // Recorded state of the 512-bit port, data spans 0x40 to 0x47
    localparam t_csr_idx CSR_WR512_DATA = 12'h040;
    localparam t_csr_idx CSR_WR512_ADDR = 12'h050;
    localparam t_csr_idx CSR_WR512_MASK = 12'h051;

    // Addresses count bus words, so the first enabled byte gives the byte offset
    // An empty mask returns the mask width
    function automatic int first_byte_idx(input logic [63:0] mask, input int width);
        int idx;

        idx = width;
        // Scan from the top so the lowest set bit is the one that remains
        for (int i = width - 1; i >= 0; i--)
        begin
            if (mask[i])
            begin
                idx = i;
            end
        end
        return idx;
    endfunction

endpackage

// File: rtl/afu_info_pkg.sv
package afu_info_pkg;

    // Accelerator identifier reported at registers 0x1 and 0x2
    localparam logic [127:0] AFU_ID = 128'h7d3a_41c2_9e58_4b16_a0f4_c35e_2b81_d96f;

    // ====================
    // Feature header
    // ====================

    // Feature type code for an AFU entry
    localparam logic [3:0] DFH_TYPE_AFU = 4'h1;

    // The block is the only entry, so the end of list bit is set
    localparam logic DFH_EOL = 1'b1;

    // Type in bits 63:60, end of list in bit 40, everything else zero
    localparam logic [63:0] DFH_VALUE = {
        DFH_TYPE_AFU,
        19'h0,
        DFH_EOL,
        40'h0
    };

    // Interface type code in the status word, zero for Avalon-style ports
    localparam logic [3:0] IFC_TYPE = 4'h0;

endpackage

// File: rtl/mmio_ifs.sv
// ====================
// Memory-mapped slave bus
// ====================

// Address counts words of DATA_W bits and byteenable selects the bytes
// A request is taken in a cycle with read or write high and waitrequest low
interface avmm_if #(
    parameter int ADDR_W = 16,
    parameter int DATA_W = 64
) ();

    logic [ADDR_W-1:0]   address;
    logic                read;
    logic                write;
    logic [DATA_W-1:0]   writedata;
    logic [DATA_W/8-1:0] byteenable;
    logic                waitrequest;
    logic [DATA_W-1:0]   readdata;
    logic                readdatavalid;

    // Host side, as seen from the top-level mapping
    modport host (
        output address, read, write, writedata, byteenable,
        input  waitrequest, readdata, readdatavalid
    );

    // The write port owns waitrequest and watches the write requests
    modport wport (
        input  address, write, writedata, byteenable,
        output waitrequest
    );

    // The read module answers reads on the same bus
    modport rport (
        input  address, read, byteenable, waitrequest,
        output readdata, readdatavalid
    );

endinterface

// ====================
// Recorded write state
// ====================

// Last accepted write of one port, held until the next one replaces it
interface wr_capture_if #(
    parameter type t_data = logic [63:0],
    parameter int  MASK_W = 8,
    parameter int  ADDR_W = 16
) ();

    t_data                       data;
    logic [MASK_W-1:0]           mask;
    logic [ADDR_W-1:0]           addr;
    // Byte offset of the first enabled byte inside the bus word
    logic [$clog2(MASK_W)-1:0]   byte_idx;

    modport src (output data, mask, addr, byte_idx);
    modport dst (input  data, mask, addr, byte_idx);

endinterface

// File: rtl/mmio_write_port.sv
// Stalls the host with a rotating waitrequest pattern and records every
// write that gets through, one instance per port width
module mmio_write_port #(
    parameter type t_data     = logic [63:0],
    parameter int  MASK_W     = 8,
    parameter int  ADDR_W     = 16,
    parameter int  WAIT_PHASE = 0,
    parameter bit  RESET_ONES = 1'b0
) (
    input  logic          clk,
    input  logic          reset_n,
    avmm_if.wport         bus,
    wr_capture_if.src     rec
);

    localparam int IDX_W = $clog2(MASK_W);

    // ====================
    // Waitrequest pattern
    // ====================

    // A single zero circulates through the ring, so the port accepts
    // in one cycle out of sixteen
    logic [15:0] wait_ring;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wait_ring <= {~15'b0, 1'b0};
        end
        else
        begin
            wait_ring <= {wait_ring[14:0], wait_ring[15]};
        end
    end

    // The phase picks which cycle of the sixteen belongs to this port
    assign bus.waitrequest = wait_ring[WAIT_PHASE];

    // ====================
    // Write recorder
    // ====================

    logic wr_accept;

    assign wr_accept = bus.write && !bus.waitrequest;

    // The record changes on the same edge that takes the write
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            // Wide port comes up all ones and the narrow one all zeros
            rec.data     <= t_data'({$bits(t_data){RESET_ONES}});
            rec.mask     <= {MASK_W{RESET_ONES}};
            rec.addr     <= {ADDR_W{RESET_ONES}};
            rec.byte_idx <= {IDX_W{RESET_ONES}};
        end
        else if (wr_accept)
        begin
            rec.data     <= t_data'(bus.writedata);
            rec.mask     <= bus.byteenable;
            rec.addr     <= bus.address;
            rec.byte_idx <= IDX_W'(mmio_test_pkg::first_byte_idx(64'(bus.byteenable), MASK_W));
        end
    end

endmodule

// File: rtl/mmio_csr_read.sv
// Answers reads on the 64-bit port from a fixed register map
// Stage one registers the request and narrows the wide groups,
// stage two selects the word by index and raises readdatavalid
module mmio_csr_read #(
    parameter int          ADDR_W        = 16,
    parameter logic [15:0] PCLK_FREQ_MHZ = 16'd250
) (
    input  logic          clk,
    input  logic          reset_n,
    avmm_if.rport         bus,
    wr_capture_if.dst     rec64,
    wr_capture_if.dst     rec512
);

    // ====================
    // Stage one
    // ====================

    logic                      read_req_q;
    mmio_test_pkg::t_csr_idx   read_idx_q;

    // A read is taken when the host asks and the port is not stalling
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            read_req_q <= 1'b0;
        end
        else
        begin
            read_req_q <= bus.read && !bus.waitrequest;
        end
    end

    // The index only matters in the cycle after a taken read
    always_ff @(posedge clk)
    begin
        read_idx_q <= mmio_test_pkg::t_csr_idx'(bus.address);
    end

    // Byte address of the request, word address times eight plus the
    // offset of the first enabled byte
    logic [2:0]        req_byte_off;
    logic [ADDR_W+2:0] req_byte_addr_full;
    logic [31:0]       req_byte_addr;

    assign req_byte_off = 3'(mmio_test_pkg::first_byte_idx(64'(bus.byteenable), 8));
    assign req_byte_addr_full = {bus.address, req_byte_off};
    assign req_byte_addr = 32'(req_byte_addr_full);

    // Header group, decoded on the low index bits only
    mmio_test_pkg::t_mmio_value hdr_q;

    always_ff @(posedge clk)
    begin
        case (bus.address[3:0])
            mmio_test_pkg::CSR_DFH[3:0]:
                hdr_q <= afu_info_pkg::DFH_VALUE;
            mmio_test_pkg::CSR_ID_L[3:0]:
                hdr_q <= afu_info_pkg::AFU_ID[63:0];
            mmio_test_pkg::CSR_ID_H[3:0]:
                hdr_q <= afu_info_pkg::AFU_ID[127:64];
            // Replicated so a 32-bit read of either half sees it
            mmio_test_pkg::CSR_REQ_ADDR[3:0]:
                hdr_q <= {req_byte_addr, req_byte_addr};
            default:
                hdr_q <= '0;
        endcase
    end

    // One lane of the wide record, chosen by the low address bits
    // It is sampled here, so a wide write on the same edge is not seen
    mmio_test_pkg::t_mmio_value lane_q;

    always_ff @(posedge clk)
    begin
        lane_q <= rec512.data[bus.address[2:0]];
    end

    // ====================
    // Stage two
    // ====================

    // Status word: clock frequency in MHz over the interface type code
    mmio_test_pkg::t_mmio_value status_word;

    assign status_word = {32'h0, PCLK_FREQ_MHZ, 12'h0, afu_info_pkg::IFC_TYPE};

    mmio_test_pkg::t_mmio_value rd_value;

    always_comb
    begin
        rd_value = '0;
        if (read_idx_q[11:4] == mmio_test_pkg::CSR_DFH[11:4])
        begin
            rd_value = hdr_q;
        end
        else if (read_idx_q[11:3] == mmio_test_pkg::CSR_WR512_DATA[11:3])
        begin
            rd_value = lane_q;
        end
        else
        begin
            case (read_idx_q)
                mmio_test_pkg::CSR_STATUS:     rd_value = status_word;
                mmio_test_pkg::CSR_WR64_DATA:  rd_value = rec64.data;
                // Word address with the byte offset packed below it
                mmio_test_pkg::CSR_WR64_ADDR:  rd_value = 64'({rec64.addr, rec64.byte_idx});
                mmio_test_pkg::CSR_WR64_MASK:  rd_value = 64'(rec64.mask);
                mmio_test_pkg::CSR_WR512_ADDR: rd_value = 64'({rec512.addr, rec512.byte_idx});
                mmio_test_pkg::CSR_WR512_MASK: rd_value = 64'(rec512.mask);
                default:                       rd_value = '0;
            endcase
        end
    end

    // Data lands two cycles after the read is taken
    always_ff @(posedge clk)
    begin
        bus.readdata <= rd_value;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            bus.readdatavalid <= 1'b0;
        end
        else
        begin
            bus.readdatavalid <= read_req_q;
        end
    end

endmodule

// File: rtl/mmio_test_top.sv
// MMIO test block with a 64-bit read/write port and a 512-bit write-only port
module mmio_test_top #(
    parameter int          ADDR_W        = 16,
    parameter logic [15:0] PCLK_FREQ_MHZ = 16'd250
) (
    input  logic                        clk,
    input  logic                        reset_n,

    // 64-bit port
    input  logic [ADDR_W-1:0]           mmio64_address,
    input  logic                        mmio64_read,
    input  logic                        mmio64_write,
    input  mmio_test_pkg::t_mmio_value  mmio64_writedata,
    input  logic [7:0]                  mmio64_byteenable,
    output logic                        mmio64_waitrequest,
    output mmio_test_pkg::t_mmio_value  mmio64_readdata,
    output logic                        mmio64_readdatavalid,

    // 512-bit port, addressed in 64-byte words
    input  logic [ADDR_W-4:0]           mmio512_address,
    input  logic                        mmio512_write,
    input  logic [511:0]                mmio512_writedata,
    input  logic [63:0]                 mmio512_byteenable,
    output logic                        mmio512_waitrequest
);

    localparam int ADDR512_W = ADDR_W - 3;

    // ====================
    // Bus mapping
    // ====================

    avmm_if #(.ADDR_W(ADDR_W), .DATA_W(64)) mmio64_bus ();
    avmm_if #(.ADDR_W(ADDR512_W), .DATA_W(512)) mmio512_bus ();

    assign mmio64_bus.address    = mmio64_address;
    assign mmio64_bus.read       = mmio64_read;
    assign mmio64_bus.write      = mmio64_write;
    assign mmio64_bus.writedata  = mmio64_writedata;
    assign mmio64_bus.byteenable = mmio64_byteenable;
    assign mmio64_waitrequest    = mmio64_bus.waitrequest;
    assign mmio64_readdata       = mmio64_bus.readdata;
    assign mmio64_readdatavalid  = mmio64_bus.readdatavalid;

    assign mmio512_bus.address    = mmio512_address;
    assign mmio512_bus.write      = mmio512_write;
    assign mmio512_bus.writedata  = mmio512_writedata;
    assign mmio512_bus.byteenable = mmio512_byteenable;
    assign mmio512_waitrequest    = mmio512_bus.waitrequest;

    // ====================
    // Instances
    // ====================

    wr_capture_if #(
        .t_data (mmio_test_pkg::t_mmio_value),
        .MASK_W (8),
        .ADDR_W (ADDR_W)
    ) rec64 ();

    wr_capture_if #(
        .t_data (mmio_test_pkg::t_mmio_line),
        .MASK_W (64),
        .ADDR_W (ADDR512_W)
    ) rec512 ();

    // Phases 0 and 8 put the two ports' accept cycles half a ring apart
    mmio_write_port #(
        .t_data     (mmio_test_pkg::t_mmio_value),
        .MASK_W     (8),
        .ADDR_W     (ADDR_W),
        .WAIT_PHASE (0),
        .RESET_ONES (1'b0)
    ) i_wport64 (
        .clk     (clk),
        .reset_n (reset_n),
        .bus     (mmio64_bus),
        .rec     (rec64)
    );

    mmio_write_port #(
        .t_data     (mmio_test_pkg::t_mmio_line),
        .MASK_W     (64),
        .ADDR_W     (ADDR512_W),
        .WAIT_PHASE (8),
        .RESET_ONES (1'b1)
    ) i_wport512 (
        .clk     (clk),
        .reset_n (reset_n),
        .bus     (mmio512_bus),
        .rec     (rec512)
    );

    mmio_csr_read #(
        .ADDR_W        (ADDR_W),
        .PCLK_FREQ_MHZ (PCLK_FREQ_MHZ)
    ) i_csr_read (
        .clk     (clk),
        .reset_n (reset_n),
        .bus     (mmio64_bus),
        .rec64   (rec64),
        .rec512  (rec512)
    );

endmodule

// File: verif/mmio_test_tb.sv
module mmio_test_tb;

    localparam int          ADDR_W     = 16;
    localparam logic [15:0] PCLK_FREQ  = 16'd250;
    localparam int          CLK_PERIOD = 10;

    // Iteration counts of the random tests
    localparam int N_UNMAPPED = 8;
    localparam int N_ADDR     = 8;
    localparam int N_WR64     = 8;
    localparam int N_WR512    = 6;

    // Test 1 reads 13 registers, a 512-bit round is one write and 13 reads
    localparam int TOTAL_REQ = 13 + 4 + N_UNMAPPED + N_ADDR + 4 * N_WR64 + 14 * N_WR512;
    localparam int WATCHDOG_CYCLES = 16 + TOTAL_REQ * 40 + 100;

    // Header word built from its fields: type AFU in 63:60, end of list in bit 40
    localparam logic [63:0] DFH_EXPECTED = (64'h1 << 60) | (64'h1 << 40);

    // Interface type code of Avalon-style ports
    localparam logic [3:0] IFC_AVALON = 4'h0;

    logic         clk;
    logic         reset_n;
    logic [15:0]  mmio64_address;
    logic         mmio64_read;
    logic         mmio64_write;
    logic [63:0]  mmio64_writedata;
    logic [7:0]   mmio64_byteenable;
    logic         mmio64_waitrequest;
    logic [63:0]  mmio64_readdata;
    logic         mmio64_readdatavalid;
    logic [12:0]  mmio512_address;
    logic         mmio512_write;
    logic [511:0] mmio512_writedata;
    logic [63:0]  mmio512_byteenable;
    logic         mmio512_waitrequest;

    integer seed;
    int     err_count;
    int     check_count;
    int     test_count;
    int     reads_accepted;
    int     pulse_count;
    bit     rdv_in_reset;

    // Model of the last write seen on each port
    logic [63:0]  m64_data;
    logic [7:0]   m64_mask;
    logic [15:0]  m64_addr;
    logic [2:0]   m64_off;
    logic [511:0] m512_data;
    logic [63:0]  m512_mask;
    logic [12:0]  m512_addr;
    logic [5:0]   m512_off;

    // Position in the sixteen-cycle stall pattern, zero right after reset
    logic [3:0]   wait_phase;
    bit           ring_running;

    mmio_test_top #(
        .ADDR_W        (ADDR_W),
        .PCLK_FREQ_MHZ (PCLK_FREQ)
    ) i_mmio_test_top (
        .clk                  (clk),
        .reset_n              (reset_n),
        .mmio64_address       (mmio64_address),
        .mmio64_read          (mmio64_read),
        .mmio64_write         (mmio64_write),
        .mmio64_writedata     (mmio64_writedata),
        .mmio64_byteenable    (mmio64_byteenable),
        .mmio64_waitrequest   (mmio64_waitrequest),
        .mmio64_readdata      (mmio64_readdata),
        .mmio64_readdatavalid (mmio64_readdatavalid),
        .mmio512_address      (mmio512_address),
        .mmio512_write        (mmio512_write),
        .mmio512_writedata    (mmio512_writedata),
        .mmio512_byteenable   (mmio512_byteenable),
        .mmio512_waitrequest  (mmio512_waitrequest)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // The stall pattern advances one step on every rising edge out of reset
    always @(posedge clk)
    begin
        if (!reset_n)
        begin
            wait_phase <= 4'h0;
            ring_running <= 1'b0;
        end
        else
        begin
            wait_phase <= wait_phase + 4'h1;
            ring_running <= 1'b1;
        end
    end

    // Outputs are looked at on the falling edge, half a cycle after they move
    always @(negedge clk)
    begin
        if (!reset_n && mmio64_readdatavalid === 1'b1)
        begin
            rdv_in_reset = 1'b1;
        end
        if (reset_n && mmio64_readdatavalid === 1'b1)
        begin
            pulse_count++;
        end
        // Narrow port accepts at step 0, the wide port half a ring later
        if (ring_running)
        begin
            check_value("mmio64_waitrequest", 64'(wait_phase != 4'h0),
                        64'(mmio64_waitrequest));
            check_value("mmio512_waitrequest", 64'(wait_phase != 4'h8),
                        64'(mmio512_waitrequest));
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    // ====================
    // Reference model
    // ====================

    // Position of the lowest enabled byte, or the width for an empty mask
    function automatic int lowest_set_bit(input logic [63:0] mask, input int width);
        int pos;

        pos = width;
        for (int i = 0; i < width; i++)
        begin
            if (mask[i] && pos == width)
            begin
                pos = i;
            end
        end
        return pos;
    endfunction

    function automatic bit is_mapped(input logic [11:0] idx);
        return idx == mmio_test_pkg::CSR_DFH || idx == mmio_test_pkg::CSR_ID_L
            || idx == mmio_test_pkg::CSR_ID_H || idx == mmio_test_pkg::CSR_REQ_ADDR
            || idx == mmio_test_pkg::CSR_STATUS || idx == mmio_test_pkg::CSR_WR64_DATA
            || idx == mmio_test_pkg::CSR_WR64_ADDR || idx == mmio_test_pkg::CSR_WR64_MASK
            || idx[11:3] == mmio_test_pkg::CSR_WR512_DATA[11:3]
            || idx == mmio_test_pkg::CSR_WR512_ADDR || idx == mmio_test_pkg::CSR_WR512_MASK;
    endfunction

    // Word the 64-bit port should return for a read of addr with byteenable be
    function automatic logic [63:0] expected_read(input logic [15:0] addr, input logic [7:0] be);
        logic [11:0] idx;
        logic [31:0] byte_addr;
        logic [63:0] value;

        idx = addr[11:0];
        byte_addr = 32'(addr) * 32'd8 + 32'(lowest_set_bit(64'(be), 8));
        value = 64'h0;
        if (idx == mmio_test_pkg::CSR_DFH)
            value = DFH_EXPECTED;
        else if (idx == mmio_test_pkg::CSR_ID_L)
            value = afu_info_pkg::AFU_ID[63:0];
        else if (idx == mmio_test_pkg::CSR_ID_H)
            value = afu_info_pkg::AFU_ID[127:64];
        else if (idx == mmio_test_pkg::CSR_REQ_ADDR)
            value = {byte_addr, byte_addr};
        else if (idx == mmio_test_pkg::CSR_STATUS)
            value = (64'(PCLK_FREQ) << 16) | 64'(IFC_AVALON);
        else if (idx == mmio_test_pkg::CSR_WR64_DATA)
            value = m64_data;
        // Recorded address reads back as the byte address of the first enabled byte
        else if (idx == mmio_test_pkg::CSR_WR64_ADDR)
            value = 64'(m64_addr) * 64'd8 + 64'(m64_off);
        else if (idx == mmio_test_pkg::CSR_WR64_MASK)
            value = {56'h0, m64_mask};
        else if (idx[11:3] == mmio_test_pkg::CSR_WR512_DATA[11:3])
            value = m512_data[64 * int'(idx[2:0]) +: 64];
        else if (idx == mmio_test_pkg::CSR_WR512_ADDR)
            value = 64'(m512_addr) * 64'd64 + 64'(m512_off);
        else if (idx == mmio_test_pkg::CSR_WR512_MASK)
            value = m512_mask;
        return value;
    endfunction

    // ====================
    // Host tasks
    // ====================

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        if (actual !== expected)
        begin
            err_count++;
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // Every host task starts and ends on a falling edge
    task automatic read64(input logic [15:0] addr, input logic [7:0] be,
                          output logic [63:0] data);
        int waited;

        data = 64'h0;
        mmio64_address = addr;
        mmio64_byteenable = be;
        mmio64_read = 1'b1;
        waited = 0;
        // A low waitrequest here means the next rising edge takes the read
        while (mmio64_waitrequest !== 1'b0 && waited < 32)
        begin
            @(negedge clk);
            waited++;
        end
        if (mmio64_waitrequest !== 1'b0)
        begin
            err_count++;
            $display("Read of address %h was never accepted", addr);
            mmio64_read = 1'b0;
        end
        else
        begin
            reads_accepted++;
            @(negedge clk);
            mmio64_read = 1'b0;
            waited = 0;
            while (mmio64_readdatavalid !== 1'b1 && waited < 8)
            begin
                @(negedge clk);
                waited++;
            end
            if (mmio64_readdatavalid !== 1'b1)
            begin
                err_count++;
                $display("Read of address %h got no readdatavalid", addr);
            end
            else
            begin
                data = mmio64_readdata;
            end
            @(negedge clk);
        end
    endtask

    task automatic read_check(input logic [15:0] addr, input logic [7:0] be);
        logic [63:0] expected;
        logic [63:0] actual;

        expected = expected_read(addr, be);
        read64(addr, be, actual);
        check_value($sformatf("mmio64_readdata idx %03h", addr[11:0]), expected, actual);
    endtask

    task automatic write64(input logic [15:0] addr, input logic [63:0] data,
                           input logic [7:0] be);
        int waited;

        mmio64_address = addr;
        mmio64_writedata = data;
        mmio64_byteenable = be;
        mmio64_write = 1'b1;
        waited = 0;
        while (mmio64_waitrequest !== 1'b0 && waited < 32)
        begin
            @(negedge clk);
            waited++;
        end
        if (mmio64_waitrequest !== 1'b0)
        begin
            err_count++;
            $display("Write to 64-bit address %h was never accepted", addr);
        end
        else
        begin
            m64_data = data;
            m64_mask = be;
            m64_addr = addr;
            m64_off = 3'(lowest_set_bit(64'(be), 8));
        end
        @(negedge clk);
        mmio64_write = 1'b0;
    endtask

    task automatic write512(input logic [12:0] addr, input logic [511:0] data,
                            input logic [63:0] be);
        int waited;

        mmio512_address = addr;
        mmio512_writedata = data;
        mmio512_byteenable = be;
        mmio512_write = 1'b1;
        waited = 0;
        while (mmio512_waitrequest !== 1'b0 && waited < 32)
        begin
            @(negedge clk);
            waited++;
        end
        if (mmio512_waitrequest !== 1'b0)
        begin
            err_count++;
            $display("Write to 512-bit address %h was never accepted", addr);
        end
        else
        begin
            m512_data = data;
            m512_mask = be;
            m512_addr = addr;
            m512_off = 6'(lowest_set_bit(be, 64));
        end
        @(negedge clk);
        mmio512_write = 1'b0;
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        test_count++;
        if (err_count == errs_before)
            $display("test %0d %s: ok", num, name);
        else
            $display("test %0d %s: %0d errors", num, name, err_count - errs_before);
    endtask

    // ====================
    // Test sequence
    // ====================

    initial
    begin
        logic [15:0]  addr;
        logic [7:0]   be8;
        logic [63:0]  be64;
        logic [63:0]  data64;
        logic [511:0] data512;
        int           errs_before;

        seed = 60;
        err_count = 0;
        check_count = 0;
        test_count = 0;
        reads_accepted = 0;
        pulse_count = 0;
        rdv_in_reset = 1'b0;
        reset_n = 1'b0;
        mmio64_address = 16'h0;
        mmio64_read = 1'b0;
        mmio64_write = 1'b0;
        mmio64_writedata = 64'h0;
        mmio64_byteenable = 8'h0;
        mmio512_address = 13'h0;
        mmio512_write = 1'b0;
        mmio512_writedata = 512'h0;
        mmio512_byteenable = 64'h0;

        // Record contents after reset: narrow port zeros, wide port all ones
        m64_data = 64'h0;
        m64_mask = 8'h0;
        m64_addr = 16'h0;
        m64_off = 3'h0;
        m512_data = {512{1'b1}};
        m512_mask = {64{1'b1}};
        m512_addr = {13{1'b1}};
        m512_off = 6'h3f;

        repeat (16) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);

        // Test 1 reads the recorded state before any write
        errs_before = err_count;
        read_check(16'(mmio_test_pkg::CSR_WR64_DATA), 8'hff);
        read_check(16'(mmio_test_pkg::CSR_WR64_ADDR), 8'hff);
        read_check(16'(mmio_test_pkg::CSR_WR64_MASK), 8'hff);
        for (int lane = 0; lane < 8; lane++)
        begin
            read_check(16'(mmio_test_pkg::CSR_WR512_DATA) + 16'(lane), 8'hff);
        end
        read_check(16'(mmio_test_pkg::CSR_WR512_ADDR), 8'hff);
        read_check(16'(mmio_test_pkg::CSR_WR512_MASK), 8'hff);
        if (rdv_in_reset)
        begin
            err_count++;
            $display("readdatavalid was high during reset");
        end
        report_test(1, "reset values", errs_before);

        errs_before = err_count;
        read_check(16'(mmio_test_pkg::CSR_DFH), 8'hff);
        read_check(16'(mmio_test_pkg::CSR_ID_L), 8'hff);
        read_check(16'(mmio_test_pkg::CSR_ID_H), 8'hff);
        read_check(16'(mmio_test_pkg::CSR_STATUS), 8'hff);
        // Upper address bits lie outside the 12-bit index and are ignored
        repeat (N_UNMAPPED)
        begin
            do
            begin
                addr = 16'($random(seed));
            end
            while (is_mapped(addr[11:0]));
            read_check(addr, 8'hff);
        end
        report_test(2, "identity and unmapped reads", errs_before);

        errs_before = err_count;
        repeat (N_ADDR)
        begin
            addr = {4'($random(seed)), 12'h008};
            be8 = 8'($random(seed));
            if (be8 == 8'h0)
                be8 = 8'h10;
            read_check(addr, be8);
        end
        report_test(3, "request byte address", errs_before);

        errs_before = err_count;
        repeat (N_WR64)
        begin
            addr = 16'($random(seed));
            data64 = {$random(seed), $random(seed)};
            be8 = 8'($random(seed));
            if (be8 == 8'h0)
                be8 = 8'h04;
            write64(addr, data64, be8);
            read_check(16'(mmio_test_pkg::CSR_WR64_DATA), 8'hff);
            read_check(16'(mmio_test_pkg::CSR_WR64_ADDR), 8'hff);
            read_check(16'(mmio_test_pkg::CSR_WR64_MASK), 8'hff);
        end
        report_test(4, "64-bit write record", errs_before);

        errs_before = err_count;
        repeat (N_WR512)
        begin
            for (int i = 0; i < 16; i++)
            begin
                data512[32 * i +: 32] = $random(seed);
            end
            // The shift moves the first enabled byte across the whole line
            be64 = {$random(seed), $random(seed)} << ($random(seed) & 63);
            if (be64 == 64'h0)
                be64 = 64'h1 << 63;
            write512(13'($random(seed)), data512, be64);
            for (int lane = 0; lane < 8; lane++)
            begin
                read_check(16'(mmio_test_pkg::CSR_WR512_DATA) + 16'(lane), 8'hff);
            end
            read_check(16'(mmio_test_pkg::CSR_WR512_ADDR), 8'hff);
            read_check(16'(mmio_test_pkg::CSR_WR512_MASK), 8'hff);
            // The 64-bit record must not move on a wide write
            read_check(16'(mmio_test_pkg::CSR_WR64_DATA), 8'hff);
            read_check(16'(mmio_test_pkg::CSR_WR64_ADDR), 8'hff);
            read_check(16'(mmio_test_pkg::CSR_WR64_MASK), 8'hff);
        end
        report_test(5, "512-bit write record", errs_before);

        // Give a stray pulse time to show up before counting
        errs_before = err_count;
        repeat (4) @(negedge clk);
        if (pulse_count != reads_accepted)
        begin
            err_count++;
            $display("%0d readdatavalid pulses for %0d accepted reads",
                     pulse_count, reads_accepted);
        end
        report_test(6, "one readdatavalid per read", errs_before);

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
        if (err_count == 0)
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: mmio_test_top.f
rtl/mmio_test_pkg.sv
rtl/afu_info_pkg.sv
rtl/mmio_ifs.sv
rtl/mmio_write_port.sv
rtl/mmio_csr_read.sv
rtl/mmio_test_top.sv
verif/mmio_test_tb.sv

// File: Makefile
# Verilator build and run of the MMIO test block testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= mmio_test_tb
FILELIST  ?= mmio_test_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only if the log holds the pass line
run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -qxF '>>> PASS' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
